// ==== hw/cdb_arbiter.sv ====
`timescale 1ns/100ps

module cdb_arbiter
    import issue_pkg::*;
(
    input  logic     mem_done,
    input  rs_tag_t  mem_tag,
    input  reg_idx_t mem_rd,
    input  xlen_t    mem_value,
    input  logic     alu_done,
    input  rs_tag_t  alu_tag,
    input  reg_idx_t alu_rd,
    input  xlen_t    alu_value,
    output logic     mem_grant,
    output logic     alu_grant,
    output logic     cdb_valid,
    output rs_tag_t  cdb_tag,
    output reg_idx_t cdb_rd,
    output xlen_t    cdb_value
);

    // memory results win, the ALU waits a cycle.
    assign mem_grant = mem_done;
    assign alu_grant = alu_done && !mem_done;
    assign cdb_valid = mem_done || alu_done;

    always_comb begin
        if (mem_done) begin
            cdb_tag   = mem_tag;
            cdb_rd    = mem_rd;
            cdb_value = mem_value;
        end else begin
            cdb_tag   = alu_tag;
            cdb_rd    = alu_rd;
            cdb_value = alu_value;
        end
    end

endmodule

// ==== hw/exec_alu.sv ====
`timescale 1ns/100ps

module exec_alu
    import issue_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     alu_issue,
    input  op_t      issue_op,
    input  xlen_t    issue_a,
    input  xlen_t    issue_b,
    input  xlen_t    issue_imm,
    input  reg_idx_t issue_rd,
    input  rs_tag_t  issue_tag,
    input  logic     grant,
    output logic     done,
    output logic     busy,
    output rs_tag_t  result_tag,
    output reg_idx_t result_rd,
    output xlen_t    result_value
);

    xlen_t alu_out;

    always_comb begin
        case (issue_op)
            op_sub:  alu_out = issue_a - issue_b;
            op_xor:  alu_out = issue_a ^ issue_b;
            op_addi: alu_out = issue_a + issue_imm;
            default: alu_out = issue_a + issue_b;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            done <= 1'b0;
        end else if (alu_issue) begin
            done <= 1'b1;
        end else if (grant) begin
            done <= 1'b0;    // result went out on the CDB.
        end
    end

    always_ff @(posedge clock) begin
        if (alu_issue) begin
            result_value <= alu_out;
            result_tag   <= issue_tag;
            result_rd    <= issue_rd;
        end
    end

    assign busy = done;

endmodule

// ==== hw/exec_mem.sv ====
`timescale 1ns/100ps

module exec_mem
    import issue_pkg::*;
#(
    parameter int MEM_WORDS = 16
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     mem_issue,
    input  op_t      issue_op,
    input  xlen_t    issue_a,
    input  xlen_t    issue_b,
    input  xlen_t    issue_imm,
    input  reg_idx_t issue_rd,
    input  rs_tag_t  issue_tag,
    input  logic     grant,
    output logic     done,
    output logic     busy,
    output rs_tag_t  result_tag,
    output reg_idx_t result_rd,
    output xlen_t    result_value,
    output logic     store_done,
    output rs_tag_t  store_tag
);

    xlen_t     ram [MEM_WORDS];
    logic      s1_valid;
    logic      s1_store;
    mem_addr_t s1_addr;
    xlen_t     s1_data;
    reg_idx_t  s1_rd;
    rs_tag_t   s1_tag;

    // stage 1 registers the address, stage 2 accesses the RAM.
    always_ff @(posedge clock) begin
        if (mem_issue) begin
            s1_store <= issue_op == op_store;
            s1_addr  <= mem_addr_t'(issue_a + issue_imm);
            s1_data  <= issue_b;
            s1_rd    <= issue_rd;
            s1_tag   <= issue_tag;
        end
        if (s1_valid) begin
            result_value <= ram[s1_addr];
            result_tag   <= s1_tag;
            result_rd    <= s1_rd;
            store_tag    <= s1_tag;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            s1_valid   <= 1'b0;
            done       <= 1'b0;
            store_done <= 1'b0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                ram[i] <= '0;
            end
        end else begin
            s1_valid   <= mem_issue;
            store_done <= s1_valid && s1_store;
            if (s1_valid && s1_store) begin
                ram[s1_addr] <= s1_data;
            end
            if (s1_valid && !s1_store) begin
                done <= 1'b1;
            end else if (grant) begin
                done <= 1'b0;
            end
        end
    end

    assign busy = s1_valid || done;    // covers issue through retirement.

endmodule

// ==== hw/issue_core.sv ====
`timescale 1ns/100ps

module issue_core
    import issue_pkg::*;
#(
    parameter int MEM_WORDS = 16
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     dispatch_valid,
    input  op_t      dispatch_op,
    input  reg_idx_t dispatch_rd,
    input  reg_idx_t dispatch_rs1,
    input  reg_idx_t dispatch_rs2,
    input  xlen_t    dispatch_imm,
    output logic     dispatch_stall,
    output logic     cdb_valid,
    output rs_tag_t  cdb_tag,
    output reg_idx_t cdb_rd,
    output xlen_t    cdb_value
);

    logic     dispatch_accept;
    logic     dispatch_writes;
    rs_tag_t  alloc_tag;
    rs_tag_t  src1_tag;
    rs_tag_t  src2_tag;
    xlen_t    src1_value;
    xlen_t    src2_value;
    logic     alu_issue;
    logic     mem_issue;
    op_t      issue_op;
    xlen_t    issue_a;
    xlen_t    issue_b;
    xlen_t    issue_imm;
    reg_idx_t issue_rd;
    rs_tag_t  issue_tag;
    logic     alu_done;
    logic     alu_busy;
    logic     alu_grant;
    rs_tag_t  alu_tag;
    reg_idx_t alu_rd;
    xlen_t    alu_value;
    logic     mem_done;
    logic     mem_busy;
    logic     mem_grant;
    rs_tag_t  mem_tag;
    reg_idx_t mem_rd;
    xlen_t    mem_value;
    logic     store_done;
    rs_tag_t  store_tag;

    map_table map_table_inst (
        .clock, .reset, .dispatch_accept, .dispatch_rd, .dispatch_writes, .alloc_tag,
        .rs1(dispatch_rs1), .rs2(dispatch_rs2),
        .cdb_valid, .cdb_tag, .cdb_rd, .cdb_value,
        .src1_tag, .src1_value, .src2_tag, .src2_value
    );

    reservation_station reservation_station_inst (
        .clock, .reset, .dispatch_valid, .dispatch_op, .dispatch_rd, .dispatch_imm,
        .src1_tag, .src1_value, .src2_tag, .src2_value, .alu_busy, .mem_busy,
        .cdb_valid, .cdb_tag, .cdb_value, .store_done, .store_tag,
        .dispatch_stall, .dispatch_accept, .dispatch_writes, .alloc_tag,
        .alu_issue, .mem_issue, .issue_op, .issue_a, .issue_b, .issue_imm,
        .issue_rd, .issue_tag
    );

    exec_alu exec_alu_inst (
        .clock, .reset, .alu_issue, .issue_op, .issue_a, .issue_b, .issue_imm,
        .issue_rd, .issue_tag, .grant(alu_grant),
        .done(alu_done), .busy(alu_busy), .result_tag(alu_tag),
        .result_rd(alu_rd), .result_value(alu_value)
    );

    exec_mem #(
        .MEM_WORDS(MEM_WORDS)
    ) exec_mem_inst (
        .clock, .reset, .mem_issue, .issue_op, .issue_a, .issue_b, .issue_imm,
        .issue_rd, .issue_tag, .grant(mem_grant),
        .done(mem_done), .busy(mem_busy), .result_tag(mem_tag),
        .result_rd(mem_rd), .result_value(mem_value), .store_done, .store_tag
    );

    cdb_arbiter cdb_arbiter_inst (
        .mem_done, .mem_tag, .mem_rd, .mem_value,
        .alu_done, .alu_tag, .alu_rd, .alu_value,
        .mem_grant, .alu_grant, .cdb_valid, .cdb_tag, .cdb_rd, .cdb_value
    );

endmodule

// ==== hw/issue_pkg.sv ====
package issue_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths and basic types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;    // register 0 reads zero and is never renamed.
    typedef logic [2:0]  rs_tag_t;     // 0 means the value is present.
    typedef logic [3:0]  mem_addr_t;

    localparam int RS_DEPTH = 5;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_xor,
        op_addi,
        op_load,
        op_store
    } op_t;

    typedef enum logic [1:0] {
        fu_alu,
        fu_load,
        fu_store
    } fu_class_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fixed slot to unit class assignment
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam fu_class_t rs_slot_class [RS_DEPTH] = '{
        fu_alu, fu_alu, fu_load, fu_load, fu_store
    };

    function automatic fu_class_t op_class(op_t op);
        case (op)
            op_load:  return fu_load;
            op_store: return fu_store;
            default:  return fu_alu;
        endcase
    endfunction

endpackage

// ==== hw/map_table.sv ====
`timescale 1ns/100ps

module map_table
    import issue_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     dispatch_accept,
    input  reg_idx_t dispatch_rd,
    input  logic     dispatch_writes,
    input  rs_tag_t  alloc_tag,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  logic     cdb_valid,
    input  rs_tag_t  cdb_tag,
    input  reg_idx_t cdb_rd,
    input  xlen_t    cdb_value,
    output rs_tag_t  src1_tag,
    output xlen_t    src1_value,
    output rs_tag_t  src2_tag,
    output xlen_t    src2_value
);

    xlen_t   reg_value [1:31];
    rs_tag_t reg_tag   [1:31];

    // a pending tag that is on the CDB right now counts as resolved.
    function automatic logic hit_cdb(reg_idx_t idx);
        return cdb_valid && reg_tag[idx] != '0 && reg_tag[idx] == cdb_tag;
    endfunction

    function automatic rs_tag_t read_tag(reg_idx_t idx);
        if (idx == '0 || hit_cdb(idx)) begin
            return '0;
        end
        return reg_tag[idx];
    endfunction

    function automatic xlen_t read_value(reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (hit_cdb(idx)) begin
            return cdb_value;
        end
        return reg_value[idx];
    endfunction

    always_comb begin
        src1_tag   = read_tag(rs1);
        src1_value = read_value(rs1);
        src2_tag   = read_tag(rs2);
        src2_value = read_value(rs2);
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                reg_value[i] <= '0;
                reg_tag[i]   <= '0;
            end
        end else begin
            for (int i = 1; i < 32; i++) begin
                if (cdb_valid && cdb_rd == reg_idx_t'(i) && reg_tag[i] == cdb_tag) begin
                    reg_value[i] <= cdb_value;
                    reg_tag[i]   <= '0;    // only if no later rename took the register.
                end
                if (dispatch_accept && dispatch_writes && dispatch_rd == reg_idx_t'(i)) begin
                    reg_tag[i] <= alloc_tag;    // the new producer wins over the clear.
                end
            end
        end
    end

endmodule

// ==== hw/reservation_station.sv ====
`timescale 1ns/100ps

module reservation_station
    import issue_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     dispatch_valid,
    input  op_t      dispatch_op,
    input  reg_idx_t dispatch_rd,
    input  xlen_t    dispatch_imm,
    input  rs_tag_t  src1_tag,
    input  xlen_t    src1_value,
    input  rs_tag_t  src2_tag,
    input  xlen_t    src2_value,
    input  logic     alu_busy,
    input  logic     mem_busy,
    input  logic     cdb_valid,
    input  rs_tag_t  cdb_tag,
    input  xlen_t    cdb_value,
    input  logic     store_done,
    input  rs_tag_t  store_tag,
    output logic     dispatch_stall,
    output logic     dispatch_accept,
    output logic     dispatch_writes,
    output rs_tag_t  alloc_tag,
    output logic     alu_issue,
    output logic     mem_issue,
    output op_t      issue_op,
    output xlen_t    issue_a,
    output xlen_t    issue_b,
    output xlen_t    issue_imm,
    output reg_idx_t issue_rd,
    output rs_tag_t  issue_tag
);

    typedef logic [2:0] slot_idx_t;

    logic      slot_busy   [RS_DEPTH];
    logic      slot_issued [RS_DEPTH];
    slot_idx_t slot_age    [RS_DEPTH];    // number of younger occupied slots.
    rs_tag_t   slot_tag1   [RS_DEPTH];
    rs_tag_t   slot_tag2   [RS_DEPTH];
    op_t       slot_op     [RS_DEPTH];
    reg_idx_t  slot_rd     [RS_DEPTH];
    xlen_t     slot_imm    [RS_DEPTH];
    xlen_t     slot_val1   [RS_DEPTH];
    xlen_t     slot_val2   [RS_DEPTH];

    logic      slot_ready  [RS_DEPTH];
    logic      slot_free   [RS_DEPTH];    // released by the CDB or by store_done.
    logic      wake1       [RS_DEPTH];
    logic      wake2       [RS_DEPTH];
    slot_idx_t next_age    [RS_DEPTH];

    logic      alloc_found;
    slot_idx_t alloc_idx;
    logic      needs_src2;
    logic      alu_found;
    logic      mem_found;
    slot_idx_t alu_idx;
    slot_idx_t mem_idx;
    slot_idx_t issue_idx;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // allocation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        alloc_found = 1'b0;
        alloc_idx   = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!slot_busy[i] && rs_slot_class[i] == op_class(dispatch_op)) begin
                alloc_found = 1'b1;
                alloc_idx   = slot_idx_t'(i);
            end
        end
    end

    assign dispatch_accept = dispatch_valid && alloc_found;
    assign dispatch_stall  = dispatch_valid && !alloc_found;
    assign dispatch_writes = dispatch_op != op_store;
    assign alloc_tag       = rs_tag_t'(alloc_idx + 3'd1);
    assign needs_src2      = dispatch_op != op_addi && dispatch_op != op_load;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // wakeup, release and age
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            slot_ready[i] = slot_busy[i] && !slot_issued[i] &&
                            slot_tag1[i] == '0 && slot_tag2[i] == '0;
            slot_free[i]  = (cdb_valid && cdb_tag == rs_tag_t'(i + 1)) ||
                            (store_done && store_tag == rs_tag_t'(i + 1));
            wake1[i]      = cdb_valid && slot_tag1[i] == cdb_tag;
            wake2[i]      = cdb_valid && slot_tag2[i] == cdb_tag;
        end
    end

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            next_age[i] = slot_age[i];
            if (dispatch_accept) begin
                next_age[i] = next_age[i] + 3'd1;
            end
            for (int j = 0; j < RS_DEPTH; j++) begin
                if (slot_free[j] && slot_busy[j] && slot_age[j] < slot_age[i]) begin
                    next_age[i] = next_age[i] - 3'd1;    // a younger slot has left.
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // selection and issue
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        alu_found = 1'b0;
        mem_found = 1'b0;
        alu_idx   = '0;
        mem_idx   = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (rs_slot_class[i] == fu_alu) begin
                if (slot_ready[i] && (!alu_found || slot_age[i] > slot_age[alu_idx])) begin
                    alu_found = 1'b1;
                    alu_idx   = slot_idx_t'(i);
                end
            end else if (slot_busy[i] && !slot_issued[i] &&
                         (!mem_found || slot_age[i] > slot_age[mem_idx])) begin
                mem_found = 1'b1;    // oldest memory op, ready or not.
                mem_idx   = slot_idx_t'(i);
            end
        end
        mem_issue = mem_found && slot_ready[mem_idx] && !mem_busy;
        alu_issue = !mem_issue && alu_found && !alu_busy;    // one shared issue bus.
        issue_idx = mem_issue ? mem_idx : alu_idx;
    end

    assign issue_op  = slot_op[issue_idx];
    assign issue_a   = slot_val1[issue_idx];
    assign issue_b   = slot_val2[issue_idx];
    assign issue_imm = slot_imm[issue_idx];
    assign issue_rd  = slot_rd[issue_idx];
    assign issue_tag = rs_tag_t'(issue_idx + 3'd1);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                slot_busy[i]   <= 1'b0;
                slot_issued[i] <= 1'b0;
                slot_age[i]    <= '0;
                slot_tag1[i]   <= '0;
                slot_tag2[i]   <= '0;
            end
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                slot_age[i] <= slot_busy[i] ? next_age[i] : '0;
                if (wake1[i]) begin
                    slot_tag1[i] <= '0;
                end
                if (wake2[i]) begin
                    slot_tag2[i] <= '0;
                end
                if ((alu_issue || mem_issue) && issue_idx == slot_idx_t'(i)) begin
                    slot_issued[i] <= 1'b1;
                end
                if (slot_free[i]) begin
                    slot_busy[i] <= 1'b0;
                end
                if (dispatch_accept && alloc_idx == slot_idx_t'(i)) begin
                    slot_busy[i]   <= 1'b1;
                    slot_issued[i] <= 1'b0;
                    slot_age[i]    <= '0;
                    slot_tag1[i]   <= src1_tag;
                    slot_tag2[i]   <= needs_src2 ? src2_tag : '0;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (wake1[i]) begin
                slot_val1[i] <= cdb_value;
            end
            if (wake2[i]) begin
                slot_val2[i] <= cdb_value;
            end
            if (dispatch_accept && alloc_idx == slot_idx_t'(i)) begin
                slot_op[i]   <= dispatch_op;
                slot_rd[i]   <= dispatch_rd;
                slot_imm[i]  <= dispatch_imm;
                slot_val1[i] <= src1_value;
                slot_val2[i] <= src2_value;
            end
        end
    end

endmodule

// ==== issue_core.f ====
hw/issue_pkg.sv
hw/map_table.sv
hw/reservation_station.sv
hw/exec_alu.sv
hw/exec_mem.sv
hw/cdb_arbiter.sv
hw/issue_core.sv
tb/issue_core_tb.sv

// ==== tb/issue_core_tb.sv ====
`timescale 1ns/100ps

module issue_core_tb
    import issue_pkg::*;
();

    localparam int DISPATCH_LIMIT = 200;
    localparam int DRAIN_LIMIT    = 1000;

    logic     clock;
    logic     reset;
    logic     dispatch_valid;
    op_t      dispatch_op;
    reg_idx_t dispatch_rd;
    reg_idx_t dispatch_rs1;
    reg_idx_t dispatch_rs2;
    xlen_t    dispatch_imm;
    logic     dispatch_stall;
    logic     cdb_valid;
    rs_tag_t  cdb_tag;
    reg_idx_t cdb_rd;
    xlen_t    cdb_value;

    logic [16:0]       lfsr_state = 17'd66964;
    xlen_t             model_reg [8];                // register 0 stays zero.
    xlen_t             model_ram [16];
    logic [37:0]       pending [$];                  // {is_load, rd, value} per accepted result.
    logic              monitor_on = 1'b0;
    int                stall_count;
    int                cdb_hit;

    issue_core #(
        .MEM_WORDS(16)
    ) issue_core_inst (
        .clock, .reset, .dispatch_valid, .dispatch_op, .dispatch_rd, .dispatch_rs1,
        .dispatch_rs2, .dispatch_imm, .dispatch_stall, .cdb_valid, .cdb_tag, .cdb_rd,
        .cdb_value
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // error reporting and random numbers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic fail_value(string name, xlen_t expected, xlen_t actual);
        $display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
                 $time, name, expected, actual);
        abort_run();
    endtask

    task automatic fail_tag(logic is_load, rs_tag_t actual);
        $display("MISMATCH time=%0t signal=cdb_tag expected=%0d or %0d actual=%0d",
                 $time, is_load ? 3 : 1, is_load ? 4 : 2, actual);
        abort_run();
    endtask

    task automatic fail_text(string reason);
        $display("ERROR time=%0t %s", $time, reason);
        abort_run();
    endtask

    function automatic logic [16:0] lfsr_step(logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};    // taps 17 and 14.
    endfunction

    function automatic int unsigned take_bits(int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = (v << 1) | lfsr_state[0];
        end
        return v;
    endfunction

    function automatic reg_idx_t pick_reg();
        int unsigned r;
        r = take_bits(3);
        return (r == 0) ? reg_idx_t'(7) : reg_idx_t'(r);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // in-order reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic model_accept(op_t op, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2,
                                xlen_t imm);
        xlen_t     a;
        xlen_t     b;
        xlen_t     result;
        mem_addr_t addr;
        a    = model_reg[rs1[2:0]];
        b    = model_reg[rs2[2:0]];
        addr = mem_addr_t'(a + imm);
        case (op)
            op_add:  result = a + b;
            op_sub:  result = a - b;
            op_xor:  result = a ^ b;
            op_addi: result = a + imm;
            op_load: result = model_ram[addr];
            default: result = '0;
        endcase
        if (op == op_store) begin
            model_ram[addr] = b;
        end else begin
            model_reg[rd[2:0]] = result;
            pending.push_back({op == op_load, rd, result});
        end
    endtask

    // alu results come from slots 0 and 1 (tags 1 and 2) and loads from slots 2 and 3.
    function automatic logic tag_fits(logic is_load, rs_tag_t tag);
        if (is_load) begin
            return tag == 3'd3 || tag == 3'd4;
        end
        return tag == 3'd1 || tag == 3'd2;
    endfunction

    function automatic int find_pending(reg_idx_t rd, xlen_t value, rs_tag_t tag,
                                        logic any_value, logic any_tag);
        for (int i = 0; i < pending.size(); i++) begin
            if (pending[i][36:32] == rd && (any_value || pending[i][31:0] == value) &&
                (any_tag || tag_fits(pending[i][37], tag))) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic report_cdb_miss();
        int any;
        int same;
        any  = find_pending(cdb_rd, '0, cdb_tag, 1'b1, 1'b1);
        same = find_pending(cdb_rd, cdb_value, cdb_tag, 1'b0, 1'b1);
        if (any < 0) begin
            fail_text($sformatf("CDB broadcast for register %0d with nothing outstanding",
                                cdb_rd));
        end else if (same >= 0) begin
            fail_tag(pending[same][37], cdb_tag);
        end else begin
            fail_value("cdb_value", pending[any][31:0], cdb_value);
        end
    endtask

    // every broadcast must retire exactly one outstanding result of its register.
    always @(negedge clock) begin
        if (monitor_on && cdb_valid) begin
            cdb_hit = find_pending(cdb_rd, cdb_value, cdb_tag, 1'b0, 1'b0);
            assert (cdb_hit >= 0) else report_cdb_miss();
            if (cdb_hit >= 0) begin
                pending.delete(cdb_hit);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_quiet();
        assert (dispatch_stall == 1'b0) else fail_value("dispatch_stall", 0, dispatch_stall);
        assert (cdb_valid == 1'b0) else fail_value("cdb_valid", 0, cdb_valid);
    endtask

    task automatic drive_op(op_t op, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2, xlen_t imm);
        int waited;
        waited = 0;
        dispatch_valid <= 1'b1;
        dispatch_op    <= op;
        dispatch_rd    <= rd;
        dispatch_rs1   <= rs1;
        dispatch_rs2   <= rs2;
        dispatch_imm   <= imm;
        @(negedge clock);
        while (dispatch_stall) begin
            stall_count++;
            waited++;
            if (waited > DISPATCH_LIMIT) begin
                fail_text("dispatch stayed stalled and was never accepted");
            end else begin
                @(negedge clock);
            end
        end
        model_accept(op, rd, rs1, rs2, imm);    // accepted on the coming edge.
        @(posedge clock);
    endtask

    task automatic drive_random(logic alu_only);
        int unsigned kind;
        op_t         op;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        xlen_t       imm;
        kind = alu_only ? take_bits(2) : take_bits(3);
        rd   = pick_reg();
        rs1  = pick_reg();
        rs2  = pick_reg();
        imm  = take_bits(4);
        case (kind)
            0:       op = op_add;
            1:       op = op_sub;
            2:       op = op_xor;
            3:       op = op_addi;
            4, 5:    op = op_load;
            default: op = op_store;
        endcase
        drive_op(op, rd, rs1, rs2, imm);
    endtask

    task automatic idle(int cycles);
        dispatch_valid <= 1'b0;
        repeat (cycles) @(posedge clock);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        dispatch_valid <= 1'b0;
        while (pending.size() != 0) begin
            waited++;
            if (waited > DRAIN_LIMIT) begin
                fail_text("outstanding results never appeared on the CDB");
            end else begin
                @(posedge clock);
            end
        end
    endtask

    initial begin
        xlen_t addr;
        reset          = 1'b1;
        dispatch_valid = 1'b1;    // an op offered during reset must still find a free slot.
        dispatch_op    = op_add;
        dispatch_rd    = '0;
        dispatch_rs1   = '0;
        dispatch_rs2   = '0;
        dispatch_imm   = '0;
        stall_count    = 0;
        for (int i = 0; i < 8; i++) model_reg[i] = '0;
        for (int i = 0; i < 16; i++) model_ram[i] = '0;
        repeat (4) begin
            @(posedge clock);
            @(negedge clock);
            check_quiet();
        end
        @(posedge clock);
        reset          <= 1'b0;
        dispatch_valid <= 1'b0;
        @(negedge clock);
        check_quiet();
        @(posedge clock);
        monitor_on = 1'b1;
        for (int r = 1; r < 8; r++) begin
            drive_op(op_addi, reg_idx_t'(r), '0, '0, xlen_t'(take_bits(4) + r));
        end
        for (int i = 0; i < 12; i++) drive_random(1'b1);
        for (int r = 1; r < 7; r++) begin
            drive_op(op_add, reg_idx_t'(r + 1), reg_idx_t'(r), reg_idx_t'(r + 1), '0);
        end
        for (int i = 0; i < 4; i++) begin
            drive_op(op_addi, 5'd3, 5'd3, '0, xlen_t'(i + 1));    // one chain on r3.
        end
        for (int i = 0; i < 4; i++) begin
            addr = take_bits(4);
            drive_op(op_store, '0, '0, pick_reg(), addr);
            drive_op(op_load, pick_reg(), '0, '0, addr);
        end
        stall_count = 0;
        for (int i = 0; i < 5; i++) drive_op(op_store, '0, '0, pick_reg(), take_bits(4));
        assert (stall_count > 0) else fail_text("no stall while the store slot was full");
        stall_count = 0;
        for (int i = 0; i < 5; i++) drive_op(op_load, pick_reg(), '0, '0, take_bits(4));
        assert (stall_count > 0) else fail_text("no stall while both load slots were full");
        for (int i = 0; i < 40; i++) begin
            drive_random(1'b0);
            if (take_bits(2) == 0) idle(2);
        end
        wait_drain();
        for (int r = 1; r < 8; r++) drive_op(op_add, reg_idx_t'(r), reg_idx_t'(r), '0, '0);
        wait_drain();
        idle(10);    // a duplicate broadcast would still show up here.
        $display("Simulation passed");
        $finish;
    end

endmodule
